//--- fault_pkg.sv
/*
 * Fault isolation package
 * Unit counts, health weights, level bounds and the shared types of the
 * fault isolation and graceful degradation controller
 */
package fault_pkg;

    // Cluster composition
    localparam int num_cores     = 4;
    localparam int num_tpus      = 2;
    localparam int num_mem_banks = 4;

    // Unit fault severity, 0 benign to 7 fatal
    typedef logic [2:0] severity_t;
    localparam severity_t sev_critical = 3'd4;

    typedef logic [7:0] health_t;
    localparam int health_full = 100;

    // Health loss per fully isolated group and per system fault
    localparam int weight_core     = 20;
    localparam int weight_tpu      = 15;
    localparam int weight_mem      = 25;
    localparam int penalty_power   = 20;
    localparam int penalty_thermal = 15;
    localparam int penalty_clock   = 10;

    // Lower health bounds of the performance levels
    localparam int level_full      = 90;
    localparam int level_high      = 75;
    localparam int level_medium    = 50;
    localparam int level_low       = 25;
    localparam int level_minimal   = 10;
    localparam int level_emergency = 5;

    typedef enum logic [3:0] {
        perf_full      = 4'd0,
        perf_high      = 4'd1,
        perf_medium    = 4'd2,
        perf_low       = 4'd3,
        perf_minimal   = 4'd4,
        perf_emergency = 4'd5,
        perf_safe      = 4'd6
    } perf_level_t;

    typedef enum logic [2:0] {
        mode_normal    = 3'd0,
        mode_degraded  = 3'd1,
        mode_isolated  = 3'd2,
        mode_recovery  = 3'd3,
        mode_emergency = 3'd4,
        mode_safe      = 3'd5,
        mode_shutdown  = 3'd6
    } system_mode_t;

    // Recovery cycle count and timeout
    typedef logic [15:0] timer_t;

endpackage

//--- fault_classifier.sv
/*
 * Fault classifier
 * Compares each unit fault against the isolation and degradation thresholds
 * and summarizes whether any fault or any critical fault is present
 */
module fault_classifier (
    input  logic [fault_pkg::num_cores-1:0]                         core_fault,
    input  logic [fault_pkg::num_tpus-1:0]                          tpu_fault,
    input  logic [fault_pkg::num_mem_banks-1:0]                     mem_fault,
    input  fault_pkg::severity_t [fault_pkg::num_cores-1:0]         core_severity,
    input  fault_pkg::severity_t [fault_pkg::num_tpus-1:0]          tpu_severity,
    input  fault_pkg::severity_t [fault_pkg::num_mem_banks-1:0]     mem_severity,
    input  logic                                                    power_fault,
    input  logic                                                    thermal_fault,
    input  logic                                                    clock_fault,
    input  fault_pkg::severity_t                                    isolation_threshold,
    input  fault_pkg::severity_t                                    degradation_threshold,
    input  logic                                                    degradation_enable,
    output logic [fault_pkg::num_cores-1:0]                         core_isolate_hit,
    output logic [fault_pkg::num_tpus-1:0]                          tpu_isolate_hit,
    output logic [fault_pkg::num_mem_banks-1:0]                     mem_isolate_hit,
    output logic [fault_pkg::num_cores-1:0]                         core_degraded,
    output logic [fault_pkg::num_tpus-1:0]                          tpu_degraded,
    output logic                                                    any_fault,
    output logic                                                    any_critical
);
    import fault_pkg::*;

    logic system_fault;

    assign system_fault = power_fault | thermal_fault | clock_fault;

    // Severity at or above the degradation bound but short of isolation
    function automatic logic in_degrade_band(input severity_t sev);
        return (sev >= degradation_threshold) && (sev < isolation_threshold);
    endfunction

    always_comb begin
        any_fault    = system_fault | (|core_fault) | (|tpu_fault) | (|mem_fault);
        any_critical = system_fault;

        for (int i = 0; i < num_cores; i++) begin
            core_isolate_hit[i] = core_fault[i] && (core_severity[i] >= isolation_threshold);
            core_degraded[i]    = degradation_enable && core_fault[i] &&
                                  in_degrade_band(core_severity[i]);
            if (core_fault[i] && core_severity[i] >= sev_critical)
                any_critical = 1'b1;
        end

        for (int i = 0; i < num_tpus; i++) begin
            tpu_isolate_hit[i] = tpu_fault[i] && (tpu_severity[i] >= isolation_threshold);
            tpu_degraded[i]    = degradation_enable && tpu_fault[i] &&
                                 in_degrade_band(tpu_severity[i]);
            if (tpu_fault[i] && tpu_severity[i] >= sev_critical)
                any_critical = 1'b1;
        end

        // Memory banks are isolated but never slowed down
        for (int i = 0; i < num_mem_banks; i++) begin
            mem_isolate_hit[i] = mem_fault[i] && (mem_severity[i] >= isolation_threshold);
            if (mem_fault[i] && mem_severity[i] >= sev_critical)
                any_critical = 1'b1;
        end
    end

endmodule

//--- isolation_tracker.sv
/*
 * Isolation tracker
 * Holds the isolation mark of every unit until a recovery attempt clears it,
 * and derives the frequency-reduce requests of the cores and tensor units
 */
module isolation_tracker (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                isolation_enable,
    input  logic                                recover,
    input  logic [fault_pkg::num_cores-1:0]     core_isolate_hit,
    input  logic [fault_pkg::num_tpus-1:0]      tpu_isolate_hit,
    input  logic [fault_pkg::num_mem_banks-1:0] mem_isolate_hit,
    input  logic [fault_pkg::num_cores-1:0]     core_degraded,
    input  logic [fault_pkg::num_tpus-1:0]      tpu_degraded,
    output logic [fault_pkg::num_cores-1:0]     core_isolated,
    output logic [fault_pkg::num_tpus-1:0]      tpu_isolated,
    output logic [fault_pkg::num_mem_banks-1:0] mem_isolated,
    output logic [fault_pkg::num_cores-1:0]     core_freq_reduce,
    output logic [fault_pkg::num_tpus-1:0]      tpu_freq_reduce
);

    // A new hit wins over the recovery clear of the same unit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            core_isolated <= '0;
            tpu_isolated  <= '0;
            mem_isolated  <= '0;
        end else if (isolation_enable) begin
            if (recover) begin
                core_isolated <= core_isolate_hit;
                tpu_isolated  <= tpu_isolate_hit;
                mem_isolated  <= mem_isolate_hit;
            end else begin
                core_isolated <= core_isolated | core_isolate_hit;
                tpu_isolated  <= tpu_isolated | tpu_isolate_hit;
                mem_isolated  <= mem_isolated | mem_isolate_hit;
            end
        end
    end

    // Isolated units also stay slowed down
    assign core_freq_reduce = core_degraded | core_isolated;
    assign tpu_freq_reduce  = tpu_degraded | tpu_isolated;

endmodule

//--- health_monitor.sv
/*
 * Health monitor
 * Scores system health from the isolated units and the system faults and
 * maps the score onto a performance level
 */
module health_monitor (
    input  logic [fault_pkg::num_cores-1:0]     core_isolated,
    input  logic [fault_pkg::num_tpus-1:0]      tpu_isolated,
    input  logic [fault_pkg::num_mem_banks-1:0] mem_isolated,
    input  logic                                power_fault,
    input  logic                                thermal_fault,
    input  logic                                clock_fault,
    output fault_pkg::health_t                  health,
    output fault_pkg::perf_level_t              performance_level
);
    import fault_pkg::*;

    int score;

    always_comb begin
        score = health_full;

        // Group loss scales with the isolated share of the group, rounded down
        score -= ($countones(core_isolated) * weight_core) / num_cores;
        score -= ($countones(tpu_isolated) * weight_tpu) / num_tpus;
        score -= ($countones(mem_isolated) * weight_mem) / num_mem_banks;

        if (power_fault)
            score -= penalty_power;
        if (thermal_fault)
            score -= penalty_thermal;
        if (clock_fault)
            score -= penalty_clock;

        if (score < 0)
            score = 0;
    end

    assign health = health_t'(score);

    always_comb begin
        if (score >= level_full)
            performance_level = perf_full;
        else if (score >= level_high)
            performance_level = perf_high;
        else if (score >= level_medium)
            performance_level = perf_medium;
        else if (score >= level_low)
            performance_level = perf_low;
        else if (score >= level_minimal)
            performance_level = perf_minimal;
        else if (score >= level_emergency)
            performance_level = perf_emergency;
        else
            performance_level = perf_safe;
    end

endmodule

//--- recovery_timer.sv
/*
 * Recovery timer
 * Counts the cycles spent in isolated mode and flags the timeout
 */
module recovery_timer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              timer_run,
    input  fault_pkg::timer_t recovery_timeout,
    output logic              expired
);
    import fault_pkg::*;

    timer_t count;

    // Restarts from zero on every entry into isolated mode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            count <= '0;
        else if (timer_run)
            count <= count + 16'd1;
        else
            count <= '0;
    end

    assign expired = (count >= recovery_timeout);

endmodule

//--- mode_controller.sv
/*
 * Mode controller
 * System mode FSM that escalates on faults and falling health, runs the
 * recovery timer and issues the one-cycle recovery strobe
 */
module mode_controller (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               any_fault,
    input  logic               any_critical,
    input  logic               expired,
    input  logic               isolation_enable,
    input  logic               degradation_enable,
    input  logic               auto_recovery_enable,
    input  fault_pkg::health_t health,
    output logic               timer_run,
    output logic               recover,
    output logic               emergency_mode,
    output logic               safe_mode
);
    import fault_pkg::*;

    system_mode_t mode;
    system_mode_t next_mode;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            mode <= mode_normal;
        else
            mode <= next_mode;
    end

    always_comb begin
        next_mode = mode;
        case (mode)
            mode_normal: begin
                if (any_critical)
                    next_mode = mode_emergency;
                else if (any_fault && isolation_enable)
                    next_mode = mode_isolated;
                else if (health < level_high && degradation_enable)
                    next_mode = mode_degraded;
            end
            mode_degraded: begin
                if (any_critical)
                    next_mode = mode_emergency;
                else if (any_fault && isolation_enable)
                    next_mode = mode_isolated;
                else if (health >= level_full)
                    next_mode = mode_normal;
            end
            mode_isolated: begin
                if (any_critical)
                    next_mode = mode_emergency;
                else if (auto_recovery_enable && expired)
                    next_mode = mode_recovery;
                else if (health >= level_full && !any_fault)
                    next_mode = mode_normal;
            end
            // Lasts a single cycle, so the strobe needs no handshake
            mode_recovery: begin
                if (any_critical)
                    next_mode = mode_emergency;
                else if (health >= level_high)
                    next_mode = mode_normal;
                else
                    next_mode = mode_isolated;
            end
            mode_emergency: begin
                if (health < level_minimal)
                    next_mode = mode_safe;
                else if (!any_critical && health >= level_low)
                    next_mode = mode_isolated;
            end
            mode_safe: begin
                if (health >= level_low && !any_critical)
                    next_mode = mode_emergency;
                else if (health < level_emergency)
                    next_mode = mode_shutdown;
            end
            // Only a reset leaves shutdown
            mode_shutdown: next_mode = mode_shutdown;
            default:       next_mode = mode_normal;
        endcase
    end

    assign timer_run      = (mode == mode_isolated);
    assign recover        = (mode == mode_recovery);
    assign emergency_mode = (mode == mode_emergency);
    assign safe_mode      = (mode == mode_safe);

endmodule

//--- fault_isolation.sv
/*
 * Fault isolation and graceful degradation controller
 * Isolates faulty cores, tensor units and memory banks, slows degraded units
 * and steps the cluster through its operating modes as health drops
 */
module fault_isolation (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic [fault_pkg::num_cores-1:0]                     core_fault,
    input  logic [fault_pkg::num_tpus-1:0]                      tpu_fault,
    input  logic [fault_pkg::num_mem_banks-1:0]                 mem_fault,
    input  fault_pkg::severity_t [fault_pkg::num_cores-1:0]     core_severity,
    input  fault_pkg::severity_t [fault_pkg::num_tpus-1:0]      tpu_severity,
    input  fault_pkg::severity_t [fault_pkg::num_mem_banks-1:0] mem_severity,
    input  logic                                                power_fault,
    input  logic                                                thermal_fault,
    input  logic                                                clock_fault,
    input  logic                                                isolation_enable,
    input  logic                                                degradation_enable,
    input  fault_pkg::severity_t                                isolation_threshold,
    input  fault_pkg::severity_t                                degradation_threshold,
    input  logic                                                auto_recovery_enable,
    input  fault_pkg::timer_t                                   recovery_timeout,
    output logic [fault_pkg::num_cores-1:0]                     core_isolated,
    output logic [fault_pkg::num_tpus-1:0]                      tpu_isolated,
    output logic [fault_pkg::num_mem_banks-1:0]                 mem_isolated,
    output logic [fault_pkg::num_cores-1:0]                     core_freq_reduce,
    output logic [fault_pkg::num_tpus-1:0]                      tpu_freq_reduce,
    output fault_pkg::health_t                                  system_health,
    output fault_pkg::perf_level_t                              performance_level,
    output logic                                                emergency_mode,
    output logic                                                safe_mode
);
    import fault_pkg::*;

    logic [num_cores-1:0]     core_isolate_hit;
    logic [num_tpus-1:0]      tpu_isolate_hit;
    logic [num_mem_banks-1:0] mem_isolate_hit;
    logic [num_cores-1:0]     core_degraded;
    logic [num_tpus-1:0]      tpu_degraded;
    logic                     any_fault;
    logic                     any_critical;
    logic                     timer_run;
    logic                     recover;
    logic                     expired;

    fault_classifier classifier0 (
        .core_fault            (core_fault),
        .tpu_fault             (tpu_fault),
        .mem_fault             (mem_fault),
        .core_severity         (core_severity),
        .tpu_severity          (tpu_severity),
        .mem_severity          (mem_severity),
        .power_fault           (power_fault),
        .thermal_fault         (thermal_fault),
        .clock_fault           (clock_fault),
        .isolation_threshold   (isolation_threshold),
        .degradation_threshold (degradation_threshold),
        .degradation_enable    (degradation_enable),
        .core_isolate_hit      (core_isolate_hit),
        .tpu_isolate_hit       (tpu_isolate_hit),
        .mem_isolate_hit       (mem_isolate_hit),
        .core_degraded         (core_degraded),
        .tpu_degraded          (tpu_degraded),
        .any_fault             (any_fault),
        .any_critical          (any_critical)
    );

    isolation_tracker tracker0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .isolation_enable (isolation_enable),
        .recover          (recover),
        .core_isolate_hit (core_isolate_hit),
        .tpu_isolate_hit  (tpu_isolate_hit),
        .mem_isolate_hit  (mem_isolate_hit),
        .core_degraded    (core_degraded),
        .tpu_degraded     (tpu_degraded),
        .core_isolated    (core_isolated),
        .tpu_isolated     (tpu_isolated),
        .mem_isolated     (mem_isolated),
        .core_freq_reduce (core_freq_reduce),
        .tpu_freq_reduce  (tpu_freq_reduce)
    );

    // Health follows the registered marks and the live system faults
    health_monitor health0 (
        .core_isolated     (core_isolated),
        .tpu_isolated      (tpu_isolated),
        .mem_isolated      (mem_isolated),
        .power_fault       (power_fault),
        .thermal_fault     (thermal_fault),
        .clock_fault       (clock_fault),
        .health            (system_health),
        .performance_level (performance_level)
    );

    recovery_timer timer0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .timer_run        (timer_run),
        .recovery_timeout (recovery_timeout),
        .expired          (expired)
    );

    mode_controller mode0 (
        .clk                  (clk),
        .rst_n                (rst_n),
        .any_fault            (any_fault),
        .any_critical         (any_critical),
        .expired              (expired),
        .isolation_enable     (isolation_enable),
        .degradation_enable   (degradation_enable),
        .auto_recovery_enable (auto_recovery_enable),
        .health               (system_health),
        .timer_run            (timer_run),
        .recover              (recover),
        .emergency_mode       (emergency_mode),
        .safe_mode            (safe_mode)
    );

endmodule

//--- tb_fault_isolation.sv
/*
 * Testbench for the fault isolation controller
 * Random faults from a fixed seed, checked every cycle against a
 * cycle model of the masks, the health score and the mode FSM
 */
module tb_fault_isolation;
    import fault_pkg::*;

    localparam int phase_a_cycles = 600;
    localparam int phase_b_cycles = 200;
    localparam int reset_cycles   = 5;
    // Both phases, two resets and some margin
    localparam int cycle_limit    = phase_a_cycles + phase_b_cycles + 2 * (reset_cycles + 1) + 188;

    logic clk;
    logic rst_n;
    logic [num_cores-1:0]            core_fault;
    logic [num_tpus-1:0]             tpu_fault;
    logic [num_mem_banks-1:0]        mem_fault;
    severity_t [num_cores-1:0]       core_severity;
    severity_t [num_tpus-1:0]        tpu_severity;
    severity_t [num_mem_banks-1:0]   mem_severity;
    logic power_fault, thermal_fault, clock_fault;
    logic isolation_enable, degradation_enable, auto_recovery_enable;
    severity_t isolation_threshold, degradation_threshold;
    timer_t recovery_timeout;
    logic [num_cores-1:0]     core_isolated, core_freq_reduce;
    logic [num_tpus-1:0]      tpu_isolated, tpu_freq_reduce;
    logic [num_mem_banks-1:0] mem_isolated;
    health_t     system_health;
    perf_level_t performance_level;
    logic emergency_mode, safe_mode;

    // Model state
    logic [7:0]   m_core, m_tpu, m_mem;
    system_mode_t m_mode;
    int           m_count;
    int           recoveries;
    int           cycle_count;
    integer       seed;
    string        test_name;

    fault_isolation dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("SIMULATION FAILED");
            $fatal(1, "Timeout: the run did not finish within %0d cycles", cycle_limit);
        end
    end

    task automatic check_mask(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("Error: %s %s expected %0h actual %0h", test_name, name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_health(input string name, input health_t exp, input health_t act);
        if (act !== exp) begin
            $display("Error: %s %s expected %0d actual %0d", test_name, name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_level(input string name, input perf_level_t exp, input perf_level_t act);
        if (act !== exp) begin
            $display("Error: %s %s expected %0d actual %0d", test_name, name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: %s %s expected %b actual %b", test_name, name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Stops the run when the stimulus missed a behavior it has to exercise
    task automatic check_reached(input logic reached, input string what);
        if (!reached) begin
            $display("SIMULATION FAILED");
            $fatal(1, "The stimulus never reached %s", what);
        end
    endtask

    function automatic int ones(input logic [7:0] v);
        int n;
        n = 0;
        for (int i = 0; i < 8; i++)
            n += v[i];
        return n;
    endfunction

    // Units whose severity reaches the isolation threshold
    function automatic logic [7:0] hits(input logic [7:0] flt, input logic [23:0] sev, input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r[i] = flt[i] && (sev[3*i +: 3] >= isolation_threshold);
        return r;
    endfunction

    function automatic logic [7:0] degrades(input logic [7:0] flt, input logic [23:0] sev,
                                            input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r[i] = degradation_enable && flt[i] && (sev[3*i +: 3] >= degradation_threshold) &&
                   (sev[3*i +: 3] < isolation_threshold);
        return r;
    endfunction

    function automatic logic critical_in(input logic [7:0] flt, input logic [23:0] sev,
                                         input int n);
        logic c;
        c = 1'b0;
        for (int i = 0; i < n; i++)
            c |= flt[i] && (sev[3*i +: 3] >= sev_critical);
        return c;
    endfunction

    function automatic int model_health();
        int h;
        h = health_full;
        h -= (ones(m_core) * weight_core) / num_cores;
        h -= (ones(m_tpu) * weight_tpu) / num_tpus;
        h -= (ones(m_mem) * weight_mem) / num_mem_banks;
        if (power_fault)
            h -= penalty_power;
        if (thermal_fault)
            h -= penalty_thermal;
        if (clock_fault)
            h -= penalty_clock;
        return (h < 0) ? 0 : h;
    endfunction

    function automatic perf_level_t perf_of(input int h);
        if (h >= 90) return perf_full;
        if (h >= 75) return perf_high;
        if (h >= 50) return perf_medium;
        if (h >= 25) return perf_low;
        if (h >= 10) return perf_minimal;
        if (h >= 5)  return perf_emergency;
        return perf_safe;
    endfunction

    function automatic system_mode_t next_mode_of(input system_mode_t m, input logic flt,
                                                  input logic crit, input logic exp, input int h);
        if (crit && m != mode_emergency && m != mode_safe && m != mode_shutdown)
            return mode_emergency;
        case (m)
            mode_normal:
                if (flt && isolation_enable) return mode_isolated;
                else if (h < 75 && degradation_enable) return mode_degraded;
            mode_degraded:
                if (flt && isolation_enable) return mode_isolated;
                else if (h >= 90) return mode_normal;
            mode_isolated:
                if (auto_recovery_enable && exp) return mode_recovery;
                else if (h >= 90 && !flt) return mode_normal;
            mode_recovery:
                return (h >= 75) ? mode_normal : mode_isolated;
            mode_emergency:
                if (h < 10) return mode_safe;
                else if (!crit && h >= 25) return mode_isolated;
            mode_safe:
                if (h >= 25 && !crit) return mode_emergency;
                else if (h < 5) return mode_shutdown;
            default: ;
        endcase
        return m;
    endfunction

    // Advance the model by one rising edge with the inputs seen at that edge
    task automatic model_clock();
        logic flt, crit;
        system_mode_t nm;
        flt  = (|core_fault) | (|tpu_fault) | (|mem_fault) | power_fault | thermal_fault |
               clock_fault;
        crit = power_fault | thermal_fault | clock_fault |
               critical_in(core_fault, core_severity, num_cores) |
               critical_in(tpu_fault, tpu_severity, num_tpus) |
               critical_in(mem_fault, mem_severity, num_mem_banks);
        nm = next_mode_of(m_mode, flt, crit, m_count >= recovery_timeout, model_health());
        if (m_mode == mode_recovery)
            recoveries++;
        if (isolation_enable) begin
            if (m_mode == mode_recovery) begin
                m_core = '0;
                m_tpu  = '0;
                m_mem  = '0;
            end
            m_core |= hits(core_fault, core_severity, num_cores);
            m_tpu  |= hits(tpu_fault, tpu_severity, num_tpus);
            m_mem  |= hits(mem_fault, mem_severity, num_mem_banks);
        end
        m_count = (m_mode == mode_isolated) ? m_count + 1 : 0;
        m_mode  = nm;
    endtask

    task automatic check_outputs();
        check_mask("core_isolated", m_core, core_isolated);
        check_mask("tpu_isolated", m_tpu, tpu_isolated);
        check_mask("mem_isolated", m_mem, mem_isolated);
        check_mask("core_freq_reduce", degrades(core_fault, core_severity, num_cores) | m_core,
                   core_freq_reduce);
        check_mask("tpu_freq_reduce", degrades(tpu_fault, tpu_severity, num_tpus) | m_tpu,
                   tpu_freq_reduce);
        check_health("system_health", health_t'(model_health()), system_health);
        check_level("performance_level", perf_of(model_health()), performance_level);
        check_flag("emergency_mode", m_mode == mode_emergency, emergency_mode);
        check_flag("safe_mode", m_mode == mode_safe, safe_mode);
    endtask

    task automatic clear_inputs();
        {core_fault, tpu_fault, mem_fault} = '0;
        {core_severity, tpu_severity, mem_severity} = '0;
        {power_fault, thermal_fault, clock_fault} = '0;
        {isolation_enable, degradation_enable, auto_recovery_enable} = '0;
        isolation_threshold   = '0;
        degradation_threshold = '0;
        recovery_timeout      = '0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        clear_inputs();
        {m_core, m_tpu, m_mem} = '0;
        m_mode  = mode_normal;
        m_count = 0;
        repeat (reset_cycles) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        test_name = "after_reset";
        check_mask("core_isolated", 8'h0, core_isolated);
        check_mask("tpu_isolated", 8'h0, tpu_isolated);
        check_mask("mem_isolated", 8'h0, mem_isolated);
        check_mask("core_freq_reduce", 8'h0, core_freq_reduce);
        check_mask("tpu_freq_reduce", 8'h0, tpu_freq_reduce);
        check_health("system_health", 8'd100, system_health);
        check_level("performance_level", perf_full, performance_level);
        check_flag("emergency_mode", 1'b0, emergency_mode);
        check_flag("safe_mode", 1'b0, safe_mode);
    endtask

    // Phase B keeps isolation on and loads the system faults heavily
    task automatic drive_inputs(input bit heavy, input int cyc);
        if (heavy) begin
            isolation_enable      = 1'b1;
            degradation_enable    = $random(seed);
            isolation_threshold   = $random(seed) & 3;
            degradation_threshold = '0;
            auto_recovery_enable  = $random(seed);
        end else if (cyc % 40 == 0) begin
            isolation_threshold   = $random(seed);
            degradation_threshold = $random(seed);
            isolation_enable      = ($random(seed) & 3) != 0;
            degradation_enable    = $random(seed);
            auto_recovery_enable  = ($random(seed) & 3) != 0;
            recovery_timeout      = $random(seed) & 15;
        end
        for (int i = 0; i < num_cores; i++)
            core_fault[i] = heavy ? $random(seed) : (($random(seed) & 15) == 0);
        for (int i = 0; i < num_tpus; i++)
            tpu_fault[i] = heavy ? $random(seed) : (($random(seed) & 15) == 0);
        for (int i = 0; i < num_mem_banks; i++)
            mem_fault[i] = heavy ? $random(seed) : (($random(seed) & 15) == 0);
        core_severity = $random(seed);
        tpu_severity  = $random(seed);
        mem_severity  = $random(seed);
        power_fault   = heavy ? (($random(seed) & 3) != 0) : (($random(seed) & 63) == 0);
        thermal_fault = heavy ? (($random(seed) & 3) != 0) : (($random(seed) & 63) == 0);
        clock_fault   = heavy ? (($random(seed) & 3) != 0) : (($random(seed) & 63) == 0);
    endtask

    task automatic run_phase(input string name, input bit heavy, input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            model_clock();
            #1;
            drive_inputs(heavy, c);
            @(negedge clk);
            test_name = name;
            check_outputs();
        end
        $display("%s done, mode %0d, recovery cycles %0d", name, m_mode, recoveries);
    endtask

    initial begin
        seed        = 32'h6327;
        rst_n       = 1'b0;
        cycle_count = 0;
        recoveries  = 0;
        clear_inputs();
        apply_reset();
        run_phase("phase_a", 1'b0, phase_a_cycles);
        check_reached(recoveries > 0, "a recovery cycle in phase_a");
        apply_reset();
        run_phase("phase_b", 1'b1, phase_b_cycles);
        // Shutdown is entered only from safe
        check_reached(m_mode == mode_shutdown, "safe and shutdown in phase_b");
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- build.f
fault_pkg.sv
fault_classifier.sv
isolation_tracker.sv
health_monitor.sv
recovery_timer.sv
mode_controller.sv
fault_isolation.sv
tb_fault_isolation.sv
